//--- verification/ndata_golden.txt
# M min | I d0..d7 keep last | O d0..d15 keep last
# Hex fields, element 0 first, keep bit i belongs to element i
M 0010

I 0001 0010 0020 000f 0011 0100 0000 ffff ff 0
I 0030 0031 0032 0033 0034 0035 0036 0037 0f 1
I 0010 0010 0010 0010 000f 000f 000f 000f ff 0
I 1234 5678 9abc def0 0008 0009 000a 000b 3c 0
I 0040 0041 0042 0043 0044 0045 0046 0047 7f 1
I 0001 0002 0003 0004 0005 0006 0007 0008 ff 1
I 0011 0022 0033 0044 0055 0066 0077 0088 ff 0
I 000f 0010 000f 0010 000f 0010 000f 0010 ff 0
I 0100 0200 0300 0400 0500 0600 0700 0800 01 0
I 0000 0000 0000 0000 0000 0000 0000 0010 80 1
I 00ff 00fe 0001 00fd 0002 00fc 0003 00fb f0 1

O 0001 0010 0020 000f 0011 0100 0000 ffff 0030 0031 0032 0033 0034 0035 0036 0037 0fb6 1
O 0010 0010 0010 0010 000f 000f 000f 000f 1234 5678 9abc def0 0008 0009 000a 000b 0c0f 0
O 0040 0041 0042 0043 0044 0045 0046 0047 0000 0000 0000 0000 0000 0000 0000 0000 007f 1
O 0001 0002 0003 0004 0005 0006 0007 0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 1
O 0011 0022 0033 0044 0055 0066 0077 0088 000f 0010 000f 0010 000f 0010 000f 0010 aaff 0
O 0100 0200 0300 0400 0500 0600 0700 0800 0000 0000 0000 0000 0000 0000 0000 0010 8001 1
O 00ff 00fe 0001 00fd 0002 00fc 0003 00fb 0000 0000 0000 0000 0000 0000 0000 0000 00a0 1

//--- project.f
+incdir+rtl
rtl/ndata_pkg.sv
rtl/ndata_reg_slice.sv
rtl/ndata_elem_filter.sv
rtl/ndata_width_converter.sv
rtl/ndata_stream_top.sv
verification/ndata_clk_gen.sv
verification/ndata_stream_checker.sv
verification/ndata_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the stream testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module ndata_tb -o ndata_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ndata_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verification/ndata_tb.sv
`timescale 1ns/1ps

`include "ndata_consts.svh"

module ndata_tb
    import ndata_pkg::*;
();

    localparam int    DRIVE_DELAY  = 10;
    localparam int    WAIT_LIMIT   = 200;
    localparam int    QUIET_CYCLES = 16;
    localparam string GOLDEN_PATH  = "verification/ndata_golden.txt";

    logic         clk;
    logic         rst_n;
    elem_t        min_value;
    narrow_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    wide_beat_t   out_beat;
    logic         out_valid;
    logic         out_ready;

    narrow_beat_t in_q[$];
    wide_beat_t   exp_q[$];
    logic         use_lfsr;     // Random back-pressure on out_ready
    logic [7:0]   lfsr_state;
    int           stalls;       // Cycles with in_valid high and in_ready low

    ndata_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ndata_stream_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .min_value (min_value),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic stop_with_fail();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            stop_with_fail();
        end
    endtask

    task automatic report_problem(input string why);
        $display("Error at time %0t: %s", $time, why);
        stop_with_fail();
    endtask

    task automatic load_golden();
        int           fd;
        int           n;
        string        line;
        logic [15:0]  v [18];
        narrow_beat_t nb;
        wide_beat_t   wb;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            report_problem("cannot open the golden file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue; // Blank or comment
            end
            case (line.getc(0))
                "M": begin
                    n = $sscanf(line, "M %h", v[0]);
                    if (n != 1) report_problem("malformed M line in golden file");
                    min_value = v[0];
                end
                "I": begin
                    n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (n != 10) report_problem("malformed I line in golden file");
                    for (int i = 0; i < `NDATA_NARROW_ELEMS; i++) begin
                        nb.data[i] = v[i];
                    end
                    nb.keep = v[8][7:0];
                    nb.last = v[9][0];
                    in_q.push_back(nb);
                end
                "O": begin
                    n = $sscanf(line,
                                "O %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                                v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17]);
                    if (n != 18) report_problem("malformed O line in golden file");
                    for (int i = 0; i < `NDATA_WIDE_ELEMS; i++) begin
                        wb.data[i] = v[i];
                    end
                    wb.keep = v[16];
                    wb.last = v[17][0];
                    exp_q.push_back(wb);
                end
                default: report_problem("unknown line kind in golden file");
            endcase
        end
        $fclose(fd);
    endtask

    // Called 10 ns after a rising edge, returns 10 ns after the transfer edge
    task automatic send_beat(input narrow_beat_t beat);
        int waited;
        waited   = 0;
        in_beat  = beat;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            if (waited >= WAIT_LIMIT) begin
                report_problem("in_ready stayed low, an input beat was never accepted");
            end
            waited++;
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic receive_beat(input wide_beat_t exp, input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(out_valid && out_ready)) begin
            if (waited >= WAIT_LIMIT) begin
                report_problem($sformatf("output beat %0d never arrived", idx));
            end
            waited++;
            @(negedge clk);
        end
        check_value(32'(out_beat.keep), 32'(exp.keep), $sformatf("keep of beat %0d", idx));
        check_value(32'(out_beat.last), 32'(exp.last), $sformatf("last of beat %0d", idx));
        for (int i = 0; i < `NDATA_WIDE_ELEMS; i++) begin
            if (exp.keep[i]) begin // Dropped elements carry no defined data
                check_value(32'(out_beat.data[i]), 32'(exp.data[i]),
                            $sformatf("element %0d of beat %0d", i, idx));
            end
        end
    endtask

    // Nothing may follow the last expected beat
    task automatic check_quiet();
        int extra;
        extra = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (out_valid) extra++;
        end
        check_value(32'(extra), 32'd0, "cycles with out_valid after the last expected beat");
    endtask

    task automatic run_pass(input logic random_ready);
        use_lfsr = random_ready; // Picked up by the out_ready driver at its next step
        stalls   = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        fork
            begin
                foreach (in_q[k]) send_beat(in_q[k]);
                in_valid = 1'b0;
            end
            begin
                foreach (exp_q[k]) receive_beat(exp_q[k], k);
            end
        join
        check_quiet();
    endtask

    // out_ready driver
    initial begin
        out_ready  = 1'b0;
        lfsr_state = 8'd53;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (use_lfsr) begin
                lfsr_state = lfsr_step(lfsr_state); // Advance once per out_ready bit
                out_ready  = lfsr_state[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        int waited;
        waited    = 0;
        in_beat   = '0;
        in_valid  = 1'b0;
        min_value = `NDATA_DEFAULT_MIN;
        use_lfsr  = 1'b0;
        stalls    = 0;
        load_golden();
        while (rst_n !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                report_problem("reset was never released");
            end
            waited++;
            @(posedge clk);
        end
        run_pass(1'b0); // Full throughput
        check_value(32'(stalls), 32'd0, "input stalls with out_ready held high");
        run_pass(1'b1); // Same traffic under back-pressure
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- verification/ndata_stream_checker.sv
`timescale 1ns/1ps

// Handshake checks on the stream top ports
module ndata_stream_checker
    import ndata_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input elem_t        min_value,
    input narrow_beat_t in_beat,
    input logic         in_valid,
    input logic         in_ready,
    input wide_beat_t   out_beat,
    input logic         out_valid,
    input logic         out_ready
);

    logic [NARROW_ELEMS-1:0] pass_mask;    // Elements at or above the threshold
    logic                    beat_empty;   // Every keep bit would be cleared
    logic                    in_upper_q;
    logic                    prev_empty_q;
    logic [15:0]             empty_fifo;   // Per packet, closing wide beat fully filtered
    logic [3:0]              wr_ptr;
    logic [3:0]              rd_ptr;
    logic                    head_empty;

    always_comb begin
        for (int i = 0; i < NARROW_ELEMS; i++) begin
            pass_mask[i] = (in_beat.data[i] >= min_value);
        end
    end

    assign beat_empty = ~|(in_beat.keep & pass_mask);
    assign head_empty = empty_fifo[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_upper_q   <= 1'b0;
            prev_empty_q <= 1'b1;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
        end else begin
            if (in_valid && in_ready) begin
                if (in_beat.last) begin
                    // A lower closing beat stands alone in its wide beat
                    empty_fifo[wr_ptr] <= beat_empty & (~in_upper_q | prev_empty_q);
                    wr_ptr             <= wr_ptr + 4'd1;
                    in_upper_q         <= 1'b0;
                end else begin
                    in_upper_q <= ~in_upper_q;
                end
                prev_empty_q <= beat_empty;
            end
            if (out_valid && out_ready && out_beat.last) begin
                rd_ptr <= rd_ptr + 4'd1;
            end
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_beat changed or out_valid dropped while stalled");

    a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else $error("in_beat changed or in_valid dropped while stalled");

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

    a_empty_last: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && out_beat.last && (out_beat.keep == '0) |-> head_empty)
        else $error("closing beat with empty keep although input elements survived");

endmodule

bind ndata_stream_top ndata_stream_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .min_value (min_value),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

//--- verification/ndata_clk_gen.sv
`timescale 1ns/1ps

// Free running clock plus a power-on reset held for a fixed number of cycles
module ndata_clk_gen #(
    parameter int HALF_PERIOD_NS = 50,
    parameter int RESET_CYCLES   = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1; // Released clear of the edge
    end

endmodule

//--- rtl/ndata_stream_top.sv
`timescale 1ns/1ps

// Input slice, element filter, 8 to 16 width converter, output slice
module ndata_stream_top
    import ndata_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  elem_t        min_value,

    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    output wide_beat_t   out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    narrow_beat_t slice_beat;  // slice_in to filter
    logic         slice_valid;
    logic         slice_ready;

    narrow_beat_t filt_beat;   // Filter to converter
    logic         filt_valid;
    logic         filt_ready;

    wide_beat_t   conv_beat;   // Converter to slice_out
    logic         conv_valid;
    logic         conv_ready;

    ndata_reg_slice #(
        .payload_t (narrow_beat_t)
    ) slice_in (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_payload  (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_payload (slice_beat),
        .out_valid   (slice_valid),
        .out_ready   (slice_ready)
    );

    ndata_elem_filter u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .min_value (min_value),
        .in_beat   (slice_beat),
        .in_valid  (slice_valid),
        .in_ready  (slice_ready),
        .out_beat  (filt_beat),
        .out_valid (filt_valid),
        .out_ready (filt_ready)
    );

    ndata_width_converter #(
        .elem_t_p (elem_t)
    ) u_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (filt_beat),
        .in_valid  (filt_valid),
        .in_ready  (filt_ready),
        .out_beat  (conv_beat),
        .out_valid (conv_valid),
        .out_ready (conv_ready)
    );

    ndata_reg_slice #(
        .payload_t (wide_beat_t)
    ) slice_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_payload  (conv_beat),
        .in_valid    (conv_valid),
        .in_ready    (conv_ready),
        .out_payload (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

//--- rtl/ndata_width_converter.sv
`timescale 1ns/1ps

// Packs two narrow beats into one wide beat. The first beat of a pair fills
// elements 0..7, the second fills 8..15. A packet ending on a lower beat is
// flushed on its own with the upper keep bits cleared.
module ndata_width_converter
    import ndata_pkg::*;
#(
    parameter type elem_t_p = elem_t
) (
    input  logic         clk,
    input  logic         rst_n,

    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    output wide_beat_t   out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Only the 2:1 ratio is handled here
    if (WIDE_ELEMS != 2 * NARROW_ELEMS) begin : g_bad_ratio
        $error("ndata_width_converter: wide count must be twice the narrow count");
    end

    elem_t_p [WIDE_ELEMS-1:0] data_q;
    logic    [WIDE_ELEMS-1:0] keep_q;
    logic                     last_q;
    logic                     valid_q;
    logic                     is_upper_q; // Next beat goes to the upper half
    logic                     take;

    // Whole stage stalls with the downstream
    assign in_ready = out_ready;
    assign take     = in_valid & out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            is_upper_q <= 1'b0;
            valid_q    <= 1'b0;
        end else if (out_ready) begin
            // Emit on a completed pair or on a packet end
            valid_q <= in_valid & (is_upper_q | in_beat.last);

            if (in_valid) begin
                if (in_beat.last) begin
                    is_upper_q <= 1'b0; // Next packet restarts low
                end else begin
                    is_upper_q <= ~is_upper_q;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (!is_upper_q) begin
                data_q[NARROW_ELEMS-1:0] <= in_beat.data;
                keep_q <= {{NARROW_ELEMS{1'b0}}, in_beat.keep}; // Upper half empty
            end else begin
                data_q[WIDE_ELEMS-1:NARROW_ELEMS] <= in_beat.data;
                keep_q[WIDE_ELEMS-1:NARROW_ELEMS] <= in_beat.keep;
            end
            last_q <= in_beat.last; // Last beat of a pair decides
        end
    end

    assign out_beat.data = data_q;
    assign out_beat.keep = keep_q;
    assign out_beat.last = last_q;
    assign out_valid     = valid_q;

endmodule

//--- rtl/ndata_elem_filter.sv
`timescale 1ns/1ps

// Single register stage that drops elements below a threshold by clearing
// their keep bits. Data values and last are passed through untouched.
module ndata_elem_filter
    import ndata_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  elem_t        min_value,

    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    output narrow_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    narrow_beat_t filtered;
    narrow_beat_t beat_q;
    logic         valid_q;
    logic         accept;

    // Output register free, or emptied on this edge
    assign in_ready = ~valid_q | out_ready;
    assign accept   = in_valid & in_ready;

    // All elements compared in parallel
    always_comb begin
        filtered = in_beat;
        for (int i = 0; i < NARROW_ELEMS; i++) begin
            filtered.keep[i] = in_beat.keep[i] & (in_beat.data[i] >= min_value);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0; // Taken with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= filtered;
        end
    end

    assign out_beat  = beat_q;
    assign out_valid = valid_q;

endmodule

//--- rtl/ndata_reg_slice.sv
`timescale 1ns/1ps

// Two-entry skid buffer. Upstream ready comes straight from a flop so the
// combinational ready path is cut, while full throughput is still possible.
module ndata_reg_slice
    import ndata_pkg::*;
#(
    parameter type payload_t = narrow_beat_t
) (
    input  logic     clk,
    input  logic     rst_n,

    input  payload_t in_payload,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_payload,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_q;       // Entry presented downstream
    payload_t skid_q;       // Second entry, filled only when main is stalled
    logic     main_valid_q;
    logic     skid_valid_q;
    logic     push;
    logic     pop;

    // Full only when the skid entry is occupied
    assign in_ready = ~skid_valid_q;

    assign push = in_valid & in_ready;
    assign pop  = main_valid_q & out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            if (pop) begin
                // Refill main from skid or from the input
                main_valid_q <= skid_valid_q | push;
                skid_valid_q <= 1'b0;
            end else if (push) begin
                main_valid_q <= 1'b1;
                skid_valid_q <= main_valid_q; // Spill into skid if main is busy
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && skid_valid_q) begin
            main_q <= skid_q; // Older entry moves up first
        end else if (push && (pop || !main_valid_q)) begin
            main_q <= in_payload;
        end

        if (push && main_valid_q && !pop) begin
            skid_q <= in_payload;
        end
    end

    assign out_payload = main_q;
    assign out_valid   = main_valid_q;

endmodule

//--- rtl/ndata_pkg.sv
package ndata_pkg;

`include "ndata_consts.svh"

    localparam int ELEM_BITS    = `NDATA_ELEM_BITS;
    localparam int NARROW_ELEMS = `NDATA_NARROW_ELEMS;
    localparam int WIDE_ELEMS   = `NDATA_WIDE_ELEMS;

    // One unsigned element
    typedef logic [ELEM_BITS-1:0] elem_t;

    // Input side beat, 137 bits
    typedef struct packed {
        elem_t [NARROW_ELEMS-1:0] data;
        logic  [NARROW_ELEMS-1:0] keep; // One bit per element
        logic                     last; // End of packet
    } narrow_beat_t;

    // Output side beat, 273 bits
    typedef struct packed {
        elem_t [WIDE_ELEMS-1:0] data;
        logic  [WIDE_ELEMS-1:0] keep;
        logic                   last;
    } wide_beat_t;

endpackage

//--- rtl/ndata_consts.svh
`ifndef NDATA_CONSTS_SVH
`define NDATA_CONSTS_SVH

// Element width in bits
`define NDATA_ELEM_BITS 16

// Elements per input beat
`define NDATA_NARROW_ELEMS 8

// Elements per output beat, two narrow beats packed together
`define NDATA_WIDE_ELEMS 16

// Threshold used when nothing else drives min_value
`define NDATA_DEFAULT_MIN 16'd20

`endif
